//--- design/pixel_pkg.sv
// pixel readout package: address map, word identifiers, bus request and output word types
package pixel_pkg;

    // register windows seen from the host
    localparam logic [15:0] fifo_base = 16'h0020;
    localparam logic [15:0] sr_base   = 16'h0100;
    localparam logic [15:0] tdc_base  = 16'h0200;
    localparam logic [15:0] seq_base  = 16'h1000;

    // pattern memory sits behind the seq_gen control registers
    localparam int seq_mem_off = 16;
    localparam int seq_depth   = 256;

    localparam int src_depth     = 8;
    localparam int out_depth     = 64;
    localparam int near_full_lvl = 56;

    // identifiers in the top nibble of every output word
    localparam logic [3:0] sr_id  = 4'b0010;
    localparam logic [3:0] hit_id = 4'b0100;

    typedef struct packed {
        logic [15:0] add;
        logic [7:0]  wdata;
        logic        rd;
        logic        wr;
    } bus_req_t;

    // first sampled bit lands in bits[15]
    typedef struct packed {
        logic [3:0]  id;
        logic [11:0] seq;
        logic [15:0] bits;
    } sr_word_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [11:0] event_cnt;
        logic [15:0] width;
    } hit_word_t;

    // the id field overlaps in both views and selects the decoding
    typedef union packed {
        sr_word_t  sr;
        hit_word_t hit;
    } data_word_u;

endpackage

//--- design/word_fifo.sv
// word fifo: first-word-fall-through buffer of 32-bit words with fill level
`timescale 1ns/1ps

module word_fifo #(
    parameter int depth = 8
) (
    input  logic                  bus_clk,
    input  logic                  arst_n,
    input  logic                  push,
    input  pixel_pkg::data_word_u push_data,
    input  logic                  pop,
    output pixel_pkg::data_word_u head,
    output logic                  empty,
    output logic                  full,
    output logic [7:0]            level
);

    pixel_pkg::data_word_u mem [depth];

    // depth is a power of two, pointers wrap on their own
    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth)-1:0] rd_ptr;
    logic                     do_push;
    logic                     do_pop;

    assign empty   = (level == 8'd0);
    assign full    = (level == 8'(depth));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];

    always_ff @(posedge bus_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= 8'd0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   level <= level + 8'd1;
                2'b01:   level <= level - 8'd1;
                default: level <= level;
            endcase
        end
    end

endmodule

//--- design/seq_gen.sv
// sequence generator: bus-loaded pattern memory played out byte by byte on seq_out
`timescale 1ns/1ps

module seq_gen (
    input  logic                bus_clk,
    input  logic                arst_n,
    input  pixel_pkg::bus_req_t bus,
    output logic [7:0]          rdata,
    output logic [7:0]          seq_out
);

    logic [7:0]  mem [pixel_pkg::seq_depth];
    logic [15:0] off;
    logic [15:0] mem_off;
    logic        in_win;
    logic        mem_sel;
    logic        start;
    logic [7:0]  size;
    logic [7:0]  rd_ptr;
    logic [7:0]  left;
    logic [7:0]  rd_idx;
    logic        busy;

    assign off     = bus.add - pixel_pkg::seq_base;
    assign mem_off = off - 16'(pixel_pkg::seq_mem_off);
    assign in_win  = (bus.add >= pixel_pkg::seq_base) &&
                     (off < 16'(pixel_pkg::seq_mem_off + pixel_pkg::seq_depth));
    assign mem_sel = in_win && (off >= 16'(pixel_pkg::seq_mem_off));
    assign start   = bus.wr && in_win && (off == 16'd0);

    // first byte goes out right on the start edge
    assign rd_idx  = start ? 8'd0 : rd_ptr;

    always_ff @(posedge bus_clk) begin
        if (bus.wr && mem_sel) begin
            mem[mem_off[7:0]] <= bus.wdata;
        end
    end

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            size <= 8'd0;
        end else if (bus.wr && in_win && off == 16'd1) begin
            size <= bus.wdata;
        end
    end

    // play counter, size 0 wraps to 255 remaining and so plays all 256 bytes
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            seq_out <= 8'd0;
            busy    <= 1'b0;
            rd_ptr  <= 8'd0;
            left    <= 8'd0;
        end else if (start) begin
            seq_out <= mem[rd_idx];
            busy    <= 1'b1;
            rd_ptr  <= 8'd1;
            left    <= size - 8'd1;
        end else if (busy && left != 8'd0) begin
            seq_out <= mem[rd_idx];
            rd_ptr  <= rd_ptr + 8'd1;
            left    <= left - 8'd1;
        end else begin
            seq_out <= 8'd0;
            busy    <= 1'b0;
        end
    end

    always_comb begin
        rdata = 8'd0;
        if (bus.rd && mem_sel) begin
            rdata = mem[mem_off[7:0]];
        end else if (bus.rd && in_win) begin
            case (off)
                16'd1:   rdata = size;
                16'd2:   rdata = {7'd0, busy};
                default: rdata = 8'd0;
            endcase
        end
    end

endmodule

//--- design/sr_rx.sv
// pixel shift-register receiver: packs sampled bits into tagged 16-bit words
`timescale 1ns/1ps

module sr_rx (
    input  logic                  bus_clk,
    input  logic                  arst_n,
    input  pixel_pkg::bus_req_t   bus,
    output logic [7:0]            rdata,
    input  logic                  sen,
    input  logic                  sdi,
    input  logic                  fifo_read,
    output logic                  fifo_empty,
    output pixel_pkg::data_word_u fifo_data
);

    logic [15:0]           sh;
    logic [3:0]            bit_cnt;
    logic [11:0]           seq_cnt;
    logic [7:0]            lost_cnt;
    logic                  push_q;
    logic                  fifo_full;
    pixel_pkg::sr_word_t   word_q;
    pixel_pkg::data_word_u push_word;

    assign push_word.sr = word_q;

    // payload path, the word is taken on the 16th sample
    always_ff @(posedge bus_clk) begin
        if (sen) begin
            sh <= {sh[14:0], sdi};
            if (bit_cnt == 4'd15) begin
                word_q.id   <= pixel_pkg::sr_id;
                word_q.seq  <= seq_cnt;
                word_q.bits <= {sh[14:0], sdi};
            end
        end
    end

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt  <= 4'd0;
            seq_cnt  <= 12'd0;
            lost_cnt <= 8'd0;
            push_q   <= 1'b0;
        end else begin
            push_q <= sen && (bit_cnt == 4'd15);
            if (sen) begin
                bit_cnt <= bit_cnt + 4'd1;
                if (bit_cnt == 4'd15) begin
                    seq_cnt <= seq_cnt + 12'd1;
                end
            end
            // word dropped when the source fifo is full
            if (push_q && fifo_full) begin
                lost_cnt <= lost_cnt + 8'd1;
            end
        end
    end

    word_fifo #(
        .depth(pixel_pkg::src_depth)
    ) fifo_inst (
        .bus_clk  (bus_clk),
        .arst_n   (arst_n),
        .push     (push_q),
        .push_data(push_word),
        .pop      (fifo_read),
        .head     (fifo_data),
        .empty    (fifo_empty),
        .full     (fifo_full),
        .level    ()
    );

    always_comb begin
        rdata = 8'd0;
        if (bus.rd && bus.add[15:4] == pixel_pkg::sr_base[15:4]) begin
            case (bus.add[3:0])
                4'd0:    rdata = seq_cnt[7:0];
                4'd1:    rdata = lost_cnt;
                default: rdata = 8'd0;
            endcase
        end
    end

endmodule

//--- design/hit_tdc.sv
// hit-width counter: synchronizes hit_or and emits one tagged word per pulse
`timescale 1ns/1ps

module hit_tdc (
    input  logic                  bus_clk,
    input  logic                  arst_n,
    input  pixel_pkg::bus_req_t   bus,
    output logic [7:0]            rdata,
    input  logic                  hit_or,
    input  logic                  fifo_read,
    output logic                  fifo_empty,
    output pixel_pkg::data_word_u fifo_data
);

    logic                  in_win;
    logic                  enable;
    logic                  hit_s1;
    logic                  hit_s2;
    logic                  hit_d;
    logic                  rise;
    logic                  fall;
    logic [15:0]           width;
    logic [11:0]           event_cnt;
    logic                  push_q;
    pixel_pkg::hit_word_t  word_q;
    pixel_pkg::data_word_u push_word;

    assign in_win        = (bus.add[15:4] == pixel_pkg::tdc_base[15:4]);
    assign rise          = hit_s2 && !hit_d;
    assign fall          = !hit_s2 && hit_d;
    assign push_word.hit = word_q;

    always_ff @(posedge bus_clk) begin
        if (fall) begin
            word_q.id        <= pixel_pkg::hit_id;
            word_q.event_cnt <= event_cnt;
            word_q.width     <= width;
        end
    end

    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            enable    <= 1'b0;
            hit_s1    <= 1'b0;
            hit_s2    <= 1'b0;
            hit_d     <= 1'b0;
            width     <= 16'd0;
            event_cnt <= 12'd0;
            push_q    <= 1'b0;
        end else begin
            // two flops against metastability, third one for edges
            hit_s1 <= hit_or;
            hit_s2 <= hit_s1;
            hit_d  <= hit_s2;
            if (bus.wr && in_win && bus.add[3:0] == 4'd0) begin
                enable <= bus.wdata[0];
            end
            if (rise) begin
                width <= 16'd1;
            end else if (hit_s2 && width != 16'hffff) begin
                width <= width + 16'd1;
            end
            push_q <= fall && enable;
            if (fall && enable) begin
                event_cnt <= event_cnt + 12'd1;
            end
        end
    end

    word_fifo #(
        .depth(pixel_pkg::src_depth)
    ) fifo_inst (
        .bus_clk  (bus_clk),
        .arst_n   (arst_n),
        .push     (push_q),
        .push_data(push_word),
        .pop      (fifo_read),
        .head     (fifo_data),
        .empty    (fifo_empty),
        .full     (),
        .level    ()
    );

    always_comb begin
        rdata = 8'd0;
        if (bus.rd && in_win) begin
            case (bus.add[3:0])
                4'd0:    rdata = {7'd0, enable};
                4'd1:    rdata = event_cnt[7:0];
                default: rdata = 8'd0;
            endcase
        end
    end

endmodule

//--- design/rr_arbiter.sv
// round-robin arbiter: merges two fifo word sources into one writer
`timescale 1ns/1ps

module rr_arbiter (
    input  logic                        bus_clk,
    input  logic                        arst_n,
    input  logic [1:0]                  empty_in,
    input  pixel_pkg::data_word_u [1:0] data_in,
    output logic [1:0]                  read_grant,
    input  logic                        out_full,
    output logic                        wr_en,
    output pixel_pkg::data_word_u       data_out
);

    // source 0 is sr_rx, source 1 is hit_tdc
    logic       last;
    logic [1:0] req;
    logic       sel;

    assign req      = ~empty_in & {2{~out_full}};
    assign wr_en    = |req;
    assign data_out = data_in[sel];

    always_comb begin
        read_grant = 2'b00;
        if (req == 2'b11) begin
            sel = ~last;
        end else begin
            sel = req[1];
        end
        if (req != 2'b00) begin
            read_grant[sel] = 1'b1;
        end
    end

    // starts as if hit_tdc went last, so sr_rx wins the first tie
    always_ff @(posedge bus_clk or negedge arst_n) begin
        if (!arst_n) begin
            last <= 1'b1;
        end else if (wr_en) begin
            last <= sel;
        end
    end

endmodule

//--- design/out_buffer.sv
// output buffer: host-side word fifo with near-full flag and status registers
`timescale 1ns/1ps

module out_buffer (
    input  logic                  bus_clk,
    input  logic                  arst_n,
    input  pixel_pkg::bus_req_t   bus,
    output logic [7:0]            rdata,
    input  logic                  wr_en,
    input  pixel_pkg::data_word_u wr_data,
    output logic                  full,
    input  logic                  fread,
    output pixel_pkg::data_word_u fd,
    output logic                  fifo_empty,
    output logic                  near_full
);

    logic [7:0] level;

    assign near_full = (level >= 8'(pixel_pkg::near_full_lvl));

    word_fifo #(
        .depth(pixel_pkg::out_depth)
    ) fifo_inst (
        .bus_clk  (bus_clk),
        .arst_n   (arst_n),
        .push     (wr_en),
        .push_data(wr_data),
        .pop      (fread),
        .head     (fd),
        .empty    (fifo_empty),
        .full     (full),
        .level    (level)
    );

    always_comb begin
        rdata = 8'd0;
        if (bus.rd && bus.add[15:4] == pixel_pkg::fifo_base[15:4]) begin
            case (bus.add[3:0])
                4'd0:    rdata = level;
                4'd1:    rdata = {7'd0, near_full};
                default: rdata = 8'd0;
            endcase
        end
    end

endmodule

//--- design/pixel_top.sv
// pixel readout top: shared register bus, chip control pins and merged word output
`timescale 1ns/1ps

module pixel_top (
    input  logic                  bus_clk,
    input  logic                  arst_n,
    input  pixel_pkg::bus_req_t   bus,
    output logic [7:0]            rdata,
    input  logic                  fread,
    output pixel_pkg::data_word_u fd,
    output logic                  fifo_empty,
    output logic                  led1,
    output logic                  sr_in,
    output logic                  global_sr_clk_en,
    output logic                  global_ctr_ld,
    output logic                  global_dac_ld,
    output logic                  pixel_sr_clk_en,
    output logic                  inject,
    input  logic                  pixel_sr_out,
    input  logic                  hit_or
);

    logic [7:0]                  seq_rdata;
    logic [7:0]                  sr_rdata;
    logic [7:0]                  tdc_rdata;
    logic [7:0]                  buf_rdata;
    logic [7:0]                  seq_out;
    logic [1:0]                  src_empty;
    logic [1:0]                  src_read;
    pixel_pkg::data_word_u [1:0] src_data;
    logic                        arb_wr;
    pixel_pkg::data_word_u       arb_data;
    logic                        buf_full;

    // blocks return zero outside their windows
    assign rdata = seq_rdata | sr_rdata | tdc_rdata | buf_rdata;

    // pattern bits to chip pins, clock enables are gated on the board
    assign sr_in            = seq_out[0];
    assign global_sr_clk_en = seq_out[1];
    assign global_ctr_ld    = seq_out[2];
    assign global_dac_ld    = seq_out[3];
    assign pixel_sr_clk_en  = seq_out[4];
    assign inject           = seq_out[5];

    seq_gen seq_gen_inst (
        .bus_clk(bus_clk),
        .arst_n (arst_n),
        .bus    (bus),
        .rdata  (seq_rdata),
        .seq_out(seq_out)
    );

    sr_rx sr_rx_inst (
        .bus_clk   (bus_clk),
        .arst_n    (arst_n),
        .bus       (bus),
        .rdata     (sr_rdata),
        .sen       (seq_out[4]),
        .sdi       (pixel_sr_out),
        .fifo_read (src_read[0]),
        .fifo_empty(src_empty[0]),
        .fifo_data (src_data[0])
    );

    hit_tdc hit_tdc_inst (
        .bus_clk   (bus_clk),
        .arst_n    (arst_n),
        .bus       (bus),
        .rdata     (tdc_rdata),
        .hit_or    (hit_or),
        .fifo_read (src_read[1]),
        .fifo_empty(src_empty[1]),
        .fifo_data (src_data[1])
    );

    rr_arbiter rr_arbiter_inst (
        .bus_clk   (bus_clk),
        .arst_n    (arst_n),
        .empty_in  (src_empty),
        .data_in   (src_data),
        .read_grant(src_read),
        .out_full  (buf_full),
        .wr_en     (arb_wr),
        .data_out  (arb_data)
    );

    out_buffer out_buffer_inst (
        .bus_clk   (bus_clk),
        .arst_n    (arst_n),
        .bus       (bus),
        .rdata     (buf_rdata),
        .wr_en     (arb_wr),
        .wr_data   (arb_data),
        .full      (buf_full),
        .fread     (fread),
        .fd        (fd),
        .fifo_empty(fifo_empty),
        .near_full (led1)
    );

endmodule

//--- testbench/tb_pixel_tasks.svh
// testbench helpers: host bus cycles and typed result compares
`ifndef tb_pixel_tasks_svh
`define tb_pixel_tasks_svh

// called on a falling edge, returns on the next falling edge
task automatic bus_write(input logic [15:0] add, input logic [7:0] data);
    bus.add   = add;
    bus.wdata = data;
    bus.wr    = 1'b1;
    @(negedge clk);
    bus.wr = 1'b0;
endtask

// rdata is combinational, sampled a little after the drive
task automatic bus_read_check(input logic [15:0] add, input logic [7:0] exp,
                              input string what);
    bus.add = add;
    bus.rd  = 1'b1;
    #1;
    check_byte(rdata, exp, what);
    @(negedge clk);
    bus.rd = 1'b0;
endtask

task automatic check_byte(input logic [7:0] got, input logic [7:0] exp,
                          input string what);
    if (got !== exp) begin
        $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        abort_run();
    end
endtask

task automatic check_word(input pixel_pkg::data_word_u got,
                          input pixel_pkg::data_word_u exp, input string what);
    if (got !== exp) begin
        $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        abort_run();
    end
endtask

`endif

//--- testbench/tb_pixel_top.sv
// testbench for the pixel readout top with table-driven bus, pattern, hit and readout checks
`timescale 1ns/1ps

module tb_pixel_top;

    typedef enum logic [2:0] {op_wr, op_rd, op_hit, op_play, op_drain, op_drop} op_t;

    typedef struct packed {
        op_t         op;
        logic [15:0] add;
        logic [7:0]  data;
        logic [8:0]  len;
    } step_t;

    logic                  clk;
    logic                  arst_n;
    pixel_pkg::bus_req_t   bus;
    logic [7:0]            rdata;
    logic                  fread;
    pixel_pkg::data_word_u fd;
    logic                  fifo_empty;
    logic                  led1;
    logic                  sr_in;
    logic                  global_sr_clk_en;
    logic                  global_ctr_ld;
    logic                  global_dac_ld;
    logic                  pixel_sr_clk_en;
    logic                  inject;
    logic                  pixel_sr_out;
    logic                  hit_or;

    step_t                 steps [$];
    pixel_pkg::data_word_u exp_sr [$];
    pixel_pkg::data_word_u exp_hit [$];
    integer                seed = 32'h0a9c_09c5;
    integer                rnd;
    integer                watchdog_ns = 0;
    logic [15:0]           sr_shift = 16'd0;
    int                    sr_nbits = 0;
    logic [11:0]           sr_seq = 12'd0;
    pixel_pkg::data_word_u sr_word;
    logic                  tdc_en = 1'b0;
    logic [11:0]           hit_evt = 12'd0;

    pixel_top pixel_top_inst (
        .bus_clk         (clk),
        .arst_n          (arst_n),
        .bus             (bus),
        .rdata           (rdata),
        .fread           (fread),
        .fd              (fd),
        .fifo_empty      (fifo_empty),
        .led1            (led1),
        .sr_in           (sr_in),
        .global_sr_clk_en(global_sr_clk_en),
        .global_ctr_ld   (global_ctr_ld),
        .global_dac_ld   (global_dac_ld),
        .pixel_sr_clk_en (pixel_sr_clk_en),
        .inject          (inject),
        .pixel_sr_out    (pixel_sr_out),
        .hit_or          (hit_or)
    );

    `include "tb_pixel_tasks.svh"

    always #4 clk = ~clk;

    // chip side of the pixel register that also builds the expected words
    always @(negedge clk) begin
        if (arst_n && pixel_sr_clk_en) begin
            rnd          = $random(seed);
            pixel_sr_out = rnd[0];
            sr_shift     = {sr_shift[14:0], rnd[0]};
            sr_nbits     = sr_nbits + 1;
            if (sr_nbits == 16) begin
                sr_word.sr.id   = pixel_pkg::sr_id;
                sr_word.sr.seq  = sr_seq;
                sr_word.sr.bits = sr_shift;
                exp_sr.push_back(sr_word);
                sr_seq   = sr_seq + 12'd1;
                sr_nbits = 0;
            end
        end
    end

    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "run stopped at first error");
    endtask

    function automatic logic [7:0] pattern_byte(input logic [7:0] base, input int idx);
        return base ^ (8'(idx * 5) & 8'h2f);
    endfunction

    task automatic check_pins(input logic [7:0] exp, input string what);
        check_byte({2'b00, inject, pixel_sr_clk_en, global_dac_ld, global_ctr_ld,
                    global_sr_clk_en, sr_in}, exp & 8'h3f, what);
    endtask

    task automatic append_step(input op_t op, input logic [15:0] add,
                               input logic [7:0] data, input int len);
        step_t s;
        s.op   = op;
        s.add  = add;
        s.data = data;
        s.len  = 9'(len);
        steps.push_back(s);
    endtask

    function automatic int step_cycles(input step_t s);
        case (s.op)
            op_hit:   return int'(s.len) + 8;
            op_play:  return 2 * int'(s.len) + 12;
            op_drain: return 3 * int'(s.len) + 12;
            default:  return 1;
        endcase
    endfunction

    // load, start, then follow the pins byte by byte
    task automatic play_pattern(input logic [7:0] base, input int n);
        bus_write(pixel_pkg::seq_base + 16'd1, 8'(n));
        for (int i = 0; i < n; i++) begin
            bus_write(pixel_pkg::seq_base + 16'(pixel_pkg::seq_mem_off + i),
                      pattern_byte(base, i));
        end
        bus_write(pixel_pkg::seq_base, 8'd0);
        for (int i = 0; i < n; i++) begin
            check_pins(pattern_byte(base, i), $sformatf("pins at pattern byte %0d", i));
            bus_read_check(pixel_pkg::seq_base + 16'd2, 8'd1, "busy during playback");
        end
        check_pins(8'd0, "pins after playback");
        bus_read_check(pixel_pkg::seq_base + 16'd2, 8'd0, "busy after playback");
        // let the last word reach the output buffer
        repeat (4) @(negedge clk);
    endtask

    task automatic hit_pulse(input int len);
        pixel_pkg::data_word_u w;
        hit_or = 1'b1;
        repeat (len) @(negedge clk);
        hit_or = 1'b0;
        repeat (7) @(negedge clk);
        if (tdc_en) begin
            w.hit.id        = pixel_pkg::hit_id;
            w.hit.event_cnt = hit_evt;
            w.hit.width     = 16'(len);
            exp_hit.push_back(w);
            hit_evt = hit_evt + 12'd1;
        end
    endtask

    // pop count words and match each against its own id stream
    task automatic drain_words(input int count);
        pixel_pkg::data_word_u got;
        pixel_pkg::data_word_u exp;
        int                    waited;
        for (int k = 0; k < count; k++) begin
            waited = 0;
            while (fifo_empty && waited < 200) begin
                @(negedge clk);
                waited++;
            end
            if (fifo_empty) begin
                $display("Timeout: output word %0d of %0d never arrived", k + 1, count);
                abort_run();
            end
            got = fd;
            if (got.sr.id == pixel_pkg::sr_id && exp_sr.size() > 0) begin
                exp = exp_sr.pop_front();
            end else if (got.hit.id == pixel_pkg::hit_id && exp_hit.size() > 0) begin
                exp = exp_hit.pop_front();
            end else begin
                $display("Mismatch at %0t ns: unexpected output word %h", $time, got);
                abort_run();
            end
            check_word(got, exp, "output word");
            fread = 1'b1;
            @(negedge clk);
            fread = 1'b0;
        end
        if (exp_sr.size() + exp_hit.size() != 0) begin
            $display("Mismatch at %0t ns: %0d expected words still missing", $time,
                     exp_sr.size() + exp_hit.size());
            abort_run();
        end
        repeat (8) @(negedge clk);
        check_byte({7'd0, fifo_empty}, 8'd1, "fifo_empty after draining");
    endtask

    task automatic build_table();
        // status registers after reset
        append_step(op_rd, pixel_pkg::seq_base + 16'd1, 8'd0, 0);
        append_step(op_rd, pixel_pkg::seq_base + 16'd2, 8'd0, 0);
        append_step(op_rd, pixel_pkg::sr_base, 8'd0, 0);
        append_step(op_rd, pixel_pkg::sr_base + 16'd1, 8'd0, 0);
        append_step(op_rd, pixel_pkg::tdc_base, 8'd0, 0);
        append_step(op_rd, pixel_pkg::tdc_base + 16'd1, 8'd0, 0);
        append_step(op_rd, pixel_pkg::fifo_base, 8'd0, 0);
        append_step(op_rd, pixel_pkg::fifo_base + 16'd1, 8'd0, 0);
        // control pattern without pixel enable
        append_step(op_play, 16'd0, 8'h2b, 12);
        append_step(op_rd, pixel_pkg::seq_base + 16'd1, 8'd12, 0);
        append_step(op_rd, pixel_pkg::seq_base + 16'd19, pattern_byte(8'h2b, 3), 0);
        append_step(op_rd, pixel_pkg::sr_base, 8'd0, 0);
        // two shift-register words
        append_step(op_play, 16'd0, 8'h10, 32);
        append_step(op_drain, 16'd0, 8'd0, 2);
        append_step(op_rd, pixel_pkg::sr_base, 8'd2, 0);
        // hit words, then pulses with the counter disabled
        append_step(op_wr, pixel_pkg::tdc_base, 8'd1, 0);
        append_step(op_hit, 16'd0, 8'd0, 3);
        append_step(op_hit, 16'd0, 8'd0, 7);
        append_step(op_hit, 16'd0, 8'd0, 1);
        append_step(op_hit, 16'd0, 8'd0, 20);
        append_step(op_rd, pixel_pkg::tdc_base + 16'd1, 8'd4, 0);
        append_step(op_drain, 16'd0, 8'd0, 4);
        append_step(op_wr, pixel_pkg::tdc_base, 8'd0, 0);
        append_step(op_hit, 16'd0, 8'd0, 5);
        append_step(op_hit, 16'd0, 8'd0, 9);
        append_step(op_rd, pixel_pkg::tdc_base + 16'd1, 8'd4, 0);
        append_step(op_drain, 16'd0, 8'd0, 0);
        // both sources mixed in the output buffer
        append_step(op_wr, pixel_pkg::tdc_base, 8'd1, 0);
        append_step(op_play, 16'd0, 8'h10, 48);
        append_step(op_hit, 16'd0, 8'd0, 4);
        append_step(op_hit, 16'd0, 8'd0, 11);
        append_step(op_play, 16'd0, 8'h30, 16);
        append_step(op_hit, 16'd0, 8'd0, 2);
        append_step(op_rd, pixel_pkg::tdc_base + 16'd1, 8'd7, 0);
        append_step(op_drain, 16'd0, 8'd0, 7);
        append_step(op_wr, pixel_pkg::tdc_base, 8'd0, 0);
        // 55 words, then the 56th sets near full
        append_step(op_play, 16'd0, 8'h10, 256);
        append_step(op_play, 16'd0, 8'h10, 256);
        append_step(op_play, 16'd0, 8'h10, 256);
        append_step(op_play, 16'd0, 8'h10, 112);
        append_step(op_rd, pixel_pkg::fifo_base, 8'd55, 0);
        append_step(op_rd, pixel_pkg::fifo_base + 16'd1, 8'd0, 0);
        append_step(op_play, 16'd0, 8'h10, 16);
        append_step(op_rd, pixel_pkg::fifo_base, 8'd56, 0);
        append_step(op_rd, pixel_pkg::fifo_base + 16'd1, 8'd1, 0);
        // buffer full, source fifo full, then 16 words dropped
        append_step(op_play, 16'd0, 8'h10, 256);
        append_step(op_rd, pixel_pkg::fifo_base, 8'd64, 0);
        append_step(op_play, 16'd0, 8'h10, 256);
        append_step(op_rd, pixel_pkg::sr_base + 16'd1, 8'd16, 0);
        append_step(op_rd, pixel_pkg::sr_base, 8'd94, 0);
        append_step(op_drop, 16'd0, 8'd0, 16);
        append_step(op_drain, 16'd0, 8'd0, 72);
        append_step(op_rd, pixel_pkg::fifo_base, 8'd0, 0);
        append_step(op_rd, pixel_pkg::fifo_base + 16'd1, 8'd0, 0);
    endtask

    initial begin : watchdog
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("Watchdog expired before the stimulus table finished");
        abort_run();
    end

    initial begin : main
        step_t                 st;
        pixel_pkg::data_word_u dropped;
        int                    total;
        clk          = 1'b0;
        arst_n       = 1'b0;
        bus          = '0;
        fread        = 1'b0;
        pixel_sr_out = 1'b0;
        hit_or       = 1'b0;
        build_table();
        total = 5;
        foreach (steps[i]) begin
            total += step_cycles(steps[i]);
        end
        // four times the table length at 8 ns per cycle
        watchdog_ns = total * 4 * 8;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        check_pins(8'd0, "pins after reset");
        check_byte({7'd0, fifo_empty}, 8'd1, "fifo_empty after reset");
        foreach (steps[i]) begin
            st = steps[i];
            case (st.op)
                op_wr: begin
                    bus_write(st.add, st.data);
                    if (st.add == pixel_pkg::tdc_base) begin
                        tdc_en = st.data[0];
                    end
                end
                op_rd: begin
                    bus_read_check(st.add, st.data, $sformatf("register %h", st.add));
                    // near full pin follows the status register
                    if (st.add == pixel_pkg::fifo_base + 16'd1) begin
                        check_byte({7'd0, led1}, st.data, "led1 near full pin");
                    end
                end
                op_hit:   hit_pulse(int'(st.len));
                op_play:  play_pattern(st.data, int'(st.len));
                op_drain: drain_words(int'(st.len));
                default: begin
                    // words the sr_rx fifo had no room for
                    repeat (int'(st.len)) begin
                        dropped = exp_sr.pop_back();
                    end
                end
            endcase
        end
        $display("Regression passed");
        $finish;
    end

endmodule

//--- list.f
+incdir+testbench
design/pixel_pkg.sv
design/word_fifo.sv
design/seq_gen.sv
design/sr_rx.sv
design/hit_tdc.sv
design/rr_arbiter.sv
design/out_buffer.sv
design/pixel_top.sv
testbench/tb_pixel_top.sv
